//--- dv/ldpcDecTbRef.svh
//----------------------------------------
// LDPC decoder testbench reference model
// encoder, expected decision, output compare
//----------------------------------------
`ifndef ldpcDecTbRefSvh
`define ldpcDecTbRefSvh

typedef llrT [cBitNum-1:0] frameLlrT;

// one expected output frame
typedef struct packed {
  tagT  tag;
  bitsT bits;
  logic decFail;
  errT  err;
} expT;

expT expQ [$];  // frames in flight, oldest first

// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  return x;
endfunction

// data in bits 0..3, parity from the code equations
function automatic bitsT encodeData(input logic [3:0] d);
  bitsT c;
  c[3:0] = d;
  c[4]   = d[0] ^ d[1] ^ d[3];
  c[5]   = d[0] ^ d[2] ^ d[3];
  c[6]   = d[1] ^ d[2] ^ d[3];
  c[7]   = ^c[6:0];  // overall parity
  return c;
endfunction

// zero syndrome iff parity bits match the data bits
function automatic logic isCodeword(input bitsT b);
  return encodeData(b[3:0]) == b;
endfunction

// strong llr per bit
function automatic frameLlrT cleanLlr(input bitsT code);
  frameLlrT l;
  for (int b = 0; b < cBitNum; b++) begin
    l[b] = code[b] ? llrT'(-7) : llrT'(7);  // negative means 1
  end
  return l;
endfunction

// stimulus with iterations holds at most one weak error,
// so the sent codeword is the expected decision
function automatic expT expectFrame(input tagT t, input bitsT code, input frameLlrT l,
                                    input int iters);
  expT  e;
  bitsT signs;
  for (int b = 0; b < cBitNum; b++) begin
    signs[b] = (l[b] < 0);
  end
  e.tag = t;
  if (iters == 0) begin
    e.bits    = signs;  // no decoding, input signs pass through
    e.decFail = !isCodeword(signs);
    e.err     = '0;
  end else begin
    e.bits    = code;
    e.decFail = 1'b0;
    e.err     = errT'($countones(signs ^ code));
  end
  return e;
endfunction

//----------------------------------------
// output compare
//----------------------------------------
initial begin : compareOut
  expT cur;
  int  beat;
  cur  = '0;
  beat = 0;
  forever begin
    @(negedge iclk);  // outputs settled here
    if (oVal) begin
      if (beat == 0) begin
        if (expQ.size() == 0) begin
          $display("ERROR t=%0t output frame arrived while no frame was expected", $time);
          errCount++;
        end else begin
          cur = expQ.pop_front();
        end
      end
      checkValue("oSop", beat == 0, oSop);
      checkValue("oEop", beat == cOutBeats - 1, oEop);
      checkValue("oTag", cur.tag, oTag);
      checkValue("dat", cur.bits[beat*cDatW +: cDatW], dat);  // lowest bits first
      checkValue("decFail", cur.decFail, decFail);
      checkValue("err", cur.err, err);
      if (beat == cOutBeats - 1) begin
        beat = 0;
        recvCount++;
      end else begin
        beat++;
      end
    end
  end
end

`endif

//--- dv/ldpcDecTb.sv
//----------------------------------------
// LDPC decoder testbench
// framed llr stimulus, output frame checks
//----------------------------------------
`default_nettype none

module ldpcDecTb;
  import ldpcDecPkg::*;

  localparam int cClkPeriod  = 10;
  localparam int cRstCycles  = 8;
  localparam int cLlrNum     = 2;
  localparam int cDatW       = 4;
  localparam int cInBeats    = cBitNum / cLlrNum;
  localparam int cOutBeats   = cBitNum / cDatW;
  localparam int cMaxIter    = 8;
  localparam int cHoldCycles = 2 * cMaxIter + 10;  // req low in back-pressure
  localparam int cFrameNum   = 25;                 // over all tests
  localparam int cTimeout    = (cFrameNum * (2 * cMaxIter + 20) + cRstCycles + cHoldCycles)
                               * cClkPeriod;

  // DUT inputs
  logic              iclk;
  logic              rstN;
  iterT              niter;
  logic              fmode;
  logic              val;
  logic              sop;
  logic              eop;
  tagT               tag;
  llrT [cLlrNum-1:0] llr;
  logic              req;
  // DUT outputs
  logic              busy;
  logic              rdy;
  logic              srcErr;
  logic              full;
  logic              oVal;
  logic              oSop;
  logic              oEop;
  tagT               oTag;
  logic [cDatW-1:0]  dat;
  logic              decFail;
  errT               err;

  logic [31:0] rngState;
  int          errCount   = 0;
  int          checkCount = 0;
  int          testCount  = 0;
  int          sentCount  = 0;
  int          recvCount  = 0;

  `include "ldpcDecTbRef.svh"

  ldpcDecWrp #(.pLlrNum(cLlrNum), .pDatW(cDatW)) u_ldpcDecWrp (
    .iclk    (iclk),
    .rstN    (rstN),
    .niter   (niter),
    .fmode   (fmode),
    .val     (val),
    .sop     (sop),
    .eop     (eop),
    .tag     (tag),
    .llr     (llr),
    .req     (req),
    .busy    (busy),
    .rdy     (rdy),
    .srcErr  (srcErr),
    .full    (full),
    .oVal    (oVal),
    .oSop    (oSop),
    .oEop    (oEop),
    .oTag    (oTag),
    .dat     (dat),
    .decFail (decFail),
    .err     (err)
  );

  initial begin
    iclk = 1'b0;
    forever #(cClkPeriod / 2) iclk = ~iclk;
  end

  initial begin
    #(cTimeout);
    $display("ERROR t=%0t watchdog expired, the frames did not all come out", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] gotVal);
    checkCount++;
    if (gotVal !== expVal) begin
      $display("CHECK FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, name, expVal, gotVal);
      errCount++;
    end
  endtask

  //----------------------------------------
  // driver
  //----------------------------------------
  task automatic sendFrame(input tagT frameTag, input frameLlrT frameLlr);
    for (int b = 0; b < cInBeats; b++) begin
      while (!rdy) begin  // rdy only moves at the clock edge
        @(posedge iclk);
        #1;
      end
      val = 1'b1;
      sop = (b == 0);
      eop = (b == cInBeats - 1);
      tag = frameTag;
      llr = frameLlr[b*cLlrNum +: cLlrNum];
      @(posedge iclk);
      #1;
    end
    val = 1'b0;
    sop = 1'b0;
    eop = 1'b0;
  endtask

  task automatic queueFrame(input tagT frameTag, input bitsT code, input frameLlrT frameLlr);
    expQ.push_back(expectFrame(frameTag, code, frameLlr, int'(niter)));
    sentCount++;
    sendFrame(frameTag, frameLlr);
  endtask

  task automatic waitIdle();
    while (recvCount != sentCount || busy) begin
      @(posedge iclk);
      #1;
    end
  endtask

  task automatic reportTest(input string name, input int frames, input int errStart);
    testCount++;
    $display("test %s: %0d frames, %0d errors", name, frames, errCount - errStart);
  endtask

  //----------------------------------------
  // tests
  //----------------------------------------
  task automatic encodeCleanFrames(input int frameNum);
    bitsT code;
    for (int i = 0; i < frameNum; i++) begin
      code = encodeData(4'(nextRand()));
      queueFrame(tagT'(i), code, cleanLlr(code));
    end
  endtask

  task automatic flipWeakBit(input int frameNum);
    bitsT     code;
    frameLlrT l;
    int       pos;
    for (int i = 0; i < frameNum; i++) begin
      code   = encodeData(4'(nextRand()));
      l      = cleanLlr(code);
      pos    = int'(nextRand() % cBitNum);
      l[pos] = code[pos] ? llrT'(1) : llrT'(-1);  // wrong sign, magnitude 1
      queueFrame(tagT'(i + 8), code, l);
    end
  endtask

  task automatic passRawSigns(input int frameNum);
    frameLlrT l;
    for (int i = 0; i < frameNum; i++) begin
      for (int b = 0; b < cBitNum; b++) begin
        l[b] = llrT'(nextRand());
      end
      queueFrame(tagT'(i + 2), '0, l);
    end
  endtask

  task automatic stallOutput();
    bitsT code;
    req = 1'b0;
    for (int i = 0; i < 3; i++) begin  // out buffer, engine and input buffer
      code = encodeData(4'(nextRand()));
      queueFrame(tagT'(10 + i), code, cleanLlr(code));
    end
    checkValue("rdy", 0, rdy);
    checkValue("full", 1, full);
    checkValue("busy", 1, busy);  // frames held in all three stages
    repeat (cHoldCycles) begin
      @(posedge iclk);
      #1;
    end
    checkValue("rdy", 0, rdy);
    checkValue("full", 1, full);
    checkValue("oVal", 0, oVal);
    req = 1'b1;
  endtask

  task automatic dropStrayBeat();
    bitsT code;
    code = encodeData(4'(nextRand()));
    queueFrame(tagT'(3), code, cleanLlr(code));
    if (rdy) begin
      $display("ERROR t=%0t rdy was high right after eop, no beat could be dropped", $time);
      errCount++;
    end
    val = 1'b1;  // stray sop beat, must be dropped
    sop = 1'b1;
    tag = tagT'(4'hf);
    for (int k = 0; k < cLlrNum; k++) begin
      llr[k] = llrT'(nextRand());
    end
    @(posedge iclk);
    #1;
    val = 1'b0;
    sop = 1'b0;
    checkValue("srcErr", 1, srcErr);
    @(posedge iclk);
    #1;
    checkValue("srcErr", 0, srcErr);  // single cycle pulse
    code = encodeData(4'(nextRand()));
    queueFrame(tagT'(4), code, cleanLlr(code));
  endtask

  initial begin
    int errStart;
    rstN     = 1'b0;
    niter    = iterT'(cMaxIter);
    fmode    = 1'b1;
    val      = 1'b0;
    sop      = 1'b0;
    eop      = 1'b0;
    tag      = '0;
    llr      = '0;
    req      = 1'b1;
    rngState = 32'd29;
    repeat (cRstCycles) @(posedge iclk);
    #1;
    rstN = 1'b1;

    errStart = errCount;
    checkValue("rdy", 1, rdy);
    checkValue("busy", 0, busy);
    checkValue("full", 0, full);
    checkValue("oVal", 0, oVal);
    checkValue("srcErr", 0, srcErr);
    reportTest("reset state", 0, errStart);

    errStart = errCount;
    encodeCleanFrames(6);
    waitIdle();
    reportTest("clean codewords", 6, errStart);

    fmode    = 1'b0;  // full iteration count
    errStart = errCount;
    flipWeakBit(4);
    waitIdle();
    reportTest("weak error fmode 0", 4, errStart);

    fmode    = 1'b1;
    errStart = errCount;
    flipWeakBit(4);
    waitIdle();
    reportTest("weak error fmode 1", 4, errStart);

    niter    = '0;
    errStart = errCount;
    passRawSigns(6);
    waitIdle();
    reportTest("zero iterations", 6, errStart);

    niter    = iterT'(2);
    errStart = errCount;
    stallOutput();
    waitIdle();
    reportTest("back-pressure", 3, errStart);

    niter    = iterT'(cMaxIter);
    errStart = errCount;
    dropStrayBeat();
    waitIdle();
    reportTest("source error", 2, errStart);

    $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+dv
rtl/ldpcDecPkg.sv
rtl/ldpcLlrBuffer.sv
rtl/ldpcCheckNode.sv
rtl/ldpcIterEngine.sv
rtl/ldpcOutBuffer.sv
rtl/ldpcDecWrp.sv
dv/ldpcDecTb.sv

//--- rtl/ldpcCheckNode.sv
//----------------------------------------
// LDPC min-sum check node
// one parity row, all edges in parallel
//----------------------------------------
`default_nettype none

module ldpcCheckNode #(
  parameter int pDeg = 4  // row degree
) (
  input  wire ldpcDecPkg::nodeT [pDeg-1:0] v2c,
  output ldpcDecPkg::nodeT      [pDeg-1:0] c2v
);
  import ldpcDecPkg::*;

  localparam int cMagW = $bits(nodeT);
  localparam int cIdxW = (pDeg > 1) ? $clog2(pDeg) : 1;

  typedef logic [cMagW-1:0] magT;

  magT  [pDeg-1:0] mag;
  logic [pDeg-1:0] sgn;
  magT             min1;      // smallest magnitude
  magT             min2;      // second smallest
  logic [cIdxW-1:0] min1Idx;  // edge holding min1
  logic            sgnProd;   // parity of all signs

  // sign and magnitude per edge
  always_comb begin
    for (int e = 0; e < pDeg; e++) begin
      sgn[e] = v2c[e][cMagW-1];
      mag[e] = sgn[e] ? magT'(-v2c[e]) : magT'(v2c[e]);
    end
  end

  // first and second minimum in one pass
  always_comb begin
    min1    = '1;
    min2    = '1;
    min1Idx = '0;
    sgnProd = 1'b0;
    for (int e = 0; e < pDeg; e++) begin
      sgnProd ^= sgn[e];
      if (mag[e] < min1) begin
        min2    = min1;
        min1    = mag[e];
        min1Idx = cIdxW'(e);
      end else if (mag[e] < min2) begin
        min2 = mag[e];
      end
    end
  end

  //----------------------------------------
  // extrinsic output per edge
  //----------------------------------------
  for (genvar e = 0; e < pDeg; e++) begin : gEdge
    magT outMag;
    assign outMag = (min1Idx == cIdxW'(e)) ? min2 : min1;  // skip own edge
    // own sign removed from the product
    assign c2v[e] = (sgnProd ^ sgn[e]) ? nodeT'(-outMag) : nodeT'(outMag);
  end

endmodule

`default_nettype wire

//--- rtl/ldpcDecPkg.sv
//----------------------------------------
// LDPC decoder shared definitions
// fixed (8,4) code, message widths, status
//----------------------------------------
`default_nettype none

package ldpcDecPkg;

  localparam int cBitNum = 8;  // code length
  localparam int cChkNum = 4;  // parity checks
  localparam int cChkDeg = 4;  // ones in every row of cH
  localparam int cColW   = $clog2(cBitNum);

  typedef logic        [cBitNum-1:0] bitsT;   // one hard-decision codeword
  typedef logic        [cChkNum-1:0] synT;    // one bit per check
  typedef logic                [7:0] iterT;   // iteration count
  typedef logic signed         [3:0] llrT;    // channel llr, negative means 1
  typedef logic signed         [5:0] nodeT;   // saturating node message
  typedef logic                [3:0] tagT;
  typedef logic                [3:0] errT;    // corrected bit count
  typedef logic          [cColW-1:0] colT;    // bit position in the codeword
  typedef bitsT        [cChkNum-1:0] hMatT;
  typedef colT         [cChkDeg-1:0] rowMapT;
  typedef rowMapT      [cChkNum-1:0] edgeMapT;

  // data at bits 0..3
  // rows 0..2 check bits 4..6, row 3 is the overall parity plus row 0
  // so every row keeps weight 4 with the same code space
  localparam hMatT cH = {
    8'b1110_0100,  // row 3
    8'b0100_1110,  // row 2  d1^d2^d3
    8'b0010_1101,  // row 1  d0^d2^d3
    8'b0001_1011   // row 0  d0^d1^d3
  };

  typedef struct packed {
    tagT  tag;
    logic decFail;  // syndrome nonzero at the end
    errT  err;
  } decStatT;

  typedef enum logic [2:0] {IDLE, LOAD, CHECK, VAR, DONE} engStateT;

  // column of the k-th one in each row
  function automatic edgeMapT buildEdgeMap();
    edgeMapT edgeMap;
    int      k;
    edgeMap = '0;
    for (int r = 0; r < cChkNum; r++) begin
      k = 0;
      for (int b = 0; b < cBitNum; b++) begin
        if (cH[r][b]) begin
          edgeMap[r][k] = colT'(b);
          k++;
        end
      end
    end
    return edgeMap;
  endfunction

  localparam edgeMapT cEdgeCol = buildEdgeMap();

endpackage

`default_nettype wire

//--- rtl/ldpcDecWrp.sv
//----------------------------------------
// LDPC decoder top level
// fixed (8,4) code, buffers and engine
//----------------------------------------
`default_nettype none

module ldpcDecWrp #(
  parameter int pLlrNum = 2,  // llr per input beat
  parameter int pDatW   = 4   // bits per output beat
) (
  input  wire logic                           iclk,
  input  wire logic                           rstN,
  input  wire ldpcDecPkg::iterT               niter,
  input  wire logic                           fmode,   // stop on zero syndrome
  // input stream
  input  wire logic                           val,
  input  wire logic                           sop,
  input  wire logic                           eop,
  input  wire ldpcDecPkg::tagT                tag,
  input  wire ldpcDecPkg::llrT [pLlrNum-1:0]  llr,
  input  wire logic                           req,
  output logic                                busy,
  output logic                                rdy,
  output logic                                srcErr,
  // output stream
  output logic                                full,
  output logic                                oVal,
  output logic                                oSop,
  output logic                                oEop,
  output ldpcDecPkg::tagT                     oTag,
  output logic [pDatW-1:0]                    dat,
  output logic                                decFail,
  output ldpcDecPkg::errT                     err
);
  import ldpcDecPkg::*;

  // input buffer to engine
  logic                frameOpen;
  logic                frameVal;
  logic                frameTake;
  llrT  [cBitNum-1:0]  frameLlr;
  tagT                 frameTag;

  // engine to output buffer
  logic                decVal;
  logic                outReady;
  logic                active;
  bitsT                decBits;
  decStatT             decStat;

  //----------------------------------------
  // datapath
  //----------------------------------------
  ldpcLlrBuffer #(.pLlrNum(pLlrNum)) u_ldpcLlrBuffer (
    .iclk      (iclk),
    .rstN      (rstN),
    .val       (val),
    .sop       (sop),
    .eop       (eop),
    .tag       (tag),
    .llr       (llr),
    .frameTake (frameTake),
    .rdy       (rdy),
    .srcErr    (srcErr),
    .frameOpen (frameOpen),
    .frameVal  (frameVal),
    .frameLlr  (frameLlr),
    .frameTag  (frameTag)
  );

  ldpcIterEngine u_ldpcIterEngine (
    .iclk      (iclk),
    .rstN      (rstN),
    .niter     (niter),
    .fmode     (fmode),
    .frameVal  (frameVal),
    .frameLlr  (frameLlr),
    .frameTag  (frameTag),
    .outReady  (outReady),
    .frameTake (frameTake),
    .decVal    (decVal),
    .decBits   (decBits),
    .decStat   (decStat),
    .active    (active)
  );

  ldpcOutBuffer #(.pDatW(pDatW)) u_ldpcOutBuffer (
    .iclk     (iclk),
    .rstN     (rstN),
    .decVal   (decVal),
    .decBits  (decBits),
    .decStat  (decStat),
    .req      (req),
    .outReady (outReady),
    .full     (full),
    .val      (oVal),
    .sop      (oSop),
    .eop      (oEop),
    .tag      (oTag),
    .dat      (dat),
    .decFail  (decFail),
    .err      (err)
  );

  // any frame between accepted sop and the last output beat
  assign busy = frameOpen | frameVal | active | full;

endmodule

`default_nettype wire

//--- rtl/ldpcIterEngine.sv
//----------------------------------------
// LDPC flooding min-sum iteration engine
// check and variable update, syndrome,
// hard decision and per frame status
//----------------------------------------
`default_nettype none

module ldpcIterEngine (
  input  wire logic                                   iclk,
  input  wire logic                                   rstN,
  input  wire ldpcDecPkg::iterT                       niter,      // requested iterations
  input  wire logic                                   fmode,      // early stop
  input  wire logic                                   frameVal,
  input  wire ldpcDecPkg::llrT [ldpcDecPkg::cBitNum-1:0] frameLlr,
  input  wire ldpcDecPkg::tagT                        frameTag,
  input  wire logic                                   outReady,
  output logic                                        frameTake,
  output logic                                        decVal,
  output ldpcDecPkg::bitsT                            decBits,
  output ldpcDecPkg::decStatT                         decStat,
  output logic                                        active
);
  import ldpcDecPkg::*;

  localparam int cNodeMax = 2 ** ($bits(nodeT) - 1) - 1;  // symmetric range
  localparam int cNodeMsb = $bits(nodeT) - 1;
  localparam int cLlrMsb  = $bits(llrT) - 1;

  typedef nodeT [cChkDeg-1:0] rowMsgT;

  engStateT              state;
  iterT                  iterLeft;
  llrT   [cBitNum-1:0]   chLlr;     // channel llr of the frame
  tagT                   tagReg;
  rowMsgT [cChkNum-1:0]  v2cReg;    // per edge, row major
  rowMsgT [cChkNum-1:0]  c2vReg;
  rowMsgT [cChkNum-1:0]  c2vW;      // from the check nodes
  rowMsgT [cChkNum-1:0]  v2cW;      // next variable messages
  nodeT  [cBitNum-1:0]   totalW;    // posterior per bit
  bitsT                  chSign;
  bitsT                  hardReg;
  bitsT                  hardW;
  synT                   synW;
  synT                   synDone;
  errT                   errCnt;
  logic                  stopW;

  function automatic nodeT satNode(input int x);
    if (x > cNodeMax) begin
      return nodeT'(cNodeMax);
    end
    if (x < -cNodeMax) begin
      return nodeT'(-cNodeMax);
    end
    return nodeT'(x);
  endfunction

  function automatic synT calcSyn(input bitsT bits);
    synT syn;
    for (int r = 0; r < cChkNum; r++) begin
      syn[r] = ^(bits & cH[r]);
    end
    return syn;
  endfunction

  //----------------------------------------
  // check nodes, one per row of cH
  //----------------------------------------
  for (genvar r = 0; r < cChkNum; r++) begin : gChk
    ldpcCheckNode #(.pDeg(cChkDeg)) u_ldpcCheckNode (
      .v2c (v2cReg[r]),
      .c2v (c2vW[r])
    );
  end

  // variable nodes, edges mapped to bits by cEdgeCol
  always_comb begin
    int sum [cBitNum];
    for (int b = 0; b < cBitNum; b++) begin
      sum[b] = int'(chLlr[b]);
    end
    for (int r = 0; r < cChkNum; r++) begin
      for (int k = 0; k < cChkDeg; k++) begin
        sum[cEdgeCol[r][k]] += int'(c2vReg[r][k]);
      end
    end
    for (int b = 0; b < cBitNum; b++) begin
      totalW[b] = satNode(sum[b]);
      hardW[b]  = totalW[b][cNodeMsb];  // negative total decides 1
      chSign[b] = chLlr[b][cLlrMsb];
    end
    for (int r = 0; r < cChkNum; r++) begin
      for (int k = 0; k < cChkDeg; k++) begin
        // extrinsic, own edge contribution removed
        v2cW[r][k] = satNode(int'(totalW[cEdgeCol[r][k]]) - int'(c2vReg[r][k]));
      end
    end
  end

  assign synW  = calcSyn(hardW);
  assign stopW = (fmode && (synW == '0)) || (iterLeft == iterT'(1));

  //----------------------------------------
  // state machine
  //----------------------------------------
  always_ff @(posedge iclk or negedge rstN) begin
    if (!rstN) begin
      state    <= IDLE;
      iterLeft <= '0;
    end else begin
      case (state)
        IDLE: if (frameVal) begin
          state <= LOAD;
        end
        LOAD: begin
          iterLeft <= niter;
          state    <= (niter == '0) ? DONE : CHECK;
        end
        CHECK: state <= VAR;
        VAR: begin
          iterLeft <= iterLeft - 1'b1;
          state    <= stopW ? DONE : CHECK;
        end
        DONE: if (outReady) begin
          state <= frameVal ? LOAD : IDLE;  // next frame may wait already
        end
        default: state <= IDLE;
      endcase
    end
  end

  // message and decision registers
  always_ff @(posedge iclk) begin
    case (state)
      LOAD: begin
        chLlr  <= frameLlr;
        tagReg <= frameTag;
        for (int r = 0; r < cChkNum; r++) begin
          for (int k = 0; k < cChkDeg; k++) begin
            v2cReg[r][k] <= nodeT'(frameLlr[cEdgeCol[r][k]]);  // sign extend
          end
        end
        for (int b = 0; b < cBitNum; b++) begin
          hardReg[b] <= frameLlr[b][cLlrMsb];  // result when niter is 0
        end
      end
      CHECK: c2vReg <= c2vW;
      VAR: begin
        v2cReg  <= v2cW;
        hardReg <= hardW;
      end
      default: begin
      end
    endcase
  end

  // status of the final decision
  always_comb begin
    errCnt = '0;
    for (int b = 0; b < cBitNum; b++) begin
      errCnt += errT'(hardReg[b] ^ chSign[b]);
    end
  end

  assign synDone   = calcSyn(hardReg);
  assign frameTake = (state == LOAD);
  assign decVal    = (state == DONE);
  assign active    = (state != IDLE);
  assign decBits   = hardReg;
  assign decStat   = '{tag: tagReg, decFail: |synDone, err: errCnt};

  aStateLegal: assert property (@(posedge iclk) disable iff (!rstN)
    state inside {IDLE, LOAD, CHECK, VAR, DONE});

endmodule

`default_nettype wire

//--- rtl/ldpcLlrBuffer.sv
//----------------------------------------
// LDPC input LLR buffer
// gathers framed beats into one frame
//----------------------------------------
`default_nettype none

module ldpcLlrBuffer #(
  parameter int pLlrNum = 2  // llr per beat
) (
  input  wire logic                                  iclk,
  input  wire logic                                  rstN,
  input  wire logic                                  val,
  input  wire logic                                  sop,
  input  wire logic                                  eop,
  input  wire ldpcDecPkg::tagT                       tag,
  input  wire ldpcDecPkg::llrT [pLlrNum-1:0]         llr,
  input  wire logic                                  frameTake,   // engine loads frame
  output logic                                       rdy,
  output logic                                       srcErr,      // beat while not ready
  output logic                                       frameOpen,   // sop seen, eop pending
  output logic                                       frameVal,    // full frame held
  output ldpcDecPkg::llrT [ldpcDecPkg::cBitNum-1:0]  frameLlr,
  output ldpcDecPkg::tagT                            frameTag
);
  import ldpcDecPkg::*;

  localparam int cBeatNum = cBitNum / pLlrNum;
  localparam int cCntW    = (cBeatNum > 1) ? $clog2(cBeatNum) : 1;

  logic [cCntW-1:0] beatCnt;  // next beat slot
  logic [cCntW-1:0] beatIdx;  // slot of the current beat
  logic             beatAcc;

  assign rdy     = !frameVal;             // one frame deep
  assign beatAcc = val && rdy;
  assign beatIdx = sop ? '0 : beatCnt;    // sop restarts placement

  //----------------------------------------
  // frame control
  //----------------------------------------
  always_ff @(posedge iclk or negedge rstN) begin
    if (!rstN) begin
      beatCnt   <= '0;
      frameOpen <= 1'b0;
      frameVal  <= 1'b0;
      srcErr    <= 1'b0;
    end else begin
      srcErr <= val && !rdy;  // beat is dropped
      if (beatAcc) begin
        beatCnt   <= beatIdx + 1'b1;
        frameOpen <= !eop;
        frameVal  <= eop;     // rdy drops next cycle
      end else if (frameTake) begin
        frameVal  <= 1'b0;
      end
    end
  end

  // llr storage, lowest positions first
  always_ff @(posedge iclk) begin
    if (beatAcc) begin
      frameLlr[beatIdx*pLlrNum +: pLlrNum] <= llr;
      if (sop) begin
        frameTag <= tag;
      end
    end
  end

  // source must close the frame exactly on its last beat
  aEopLast: assert property (@(posedge iclk) disable iff (!rstN)
    (beatAcc && eop) |-> (beatIdx == cCntW'(cBeatNum - 1)));

endmodule

`default_nettype wire

//--- rtl/ldpcOutBuffer.sv
//----------------------------------------
// LDPC output buffer
// one decoded frame, streamed on request
//----------------------------------------
`default_nettype none

module ldpcOutBuffer #(
  parameter int pDatW = 4  // bits per beat
) (
  input  wire logic                 iclk,
  input  wire logic                 rstN,
  input  wire logic                 decVal,
  input  wire ldpcDecPkg::bitsT     decBits,
  input  wire ldpcDecPkg::decStatT  decStat,
  input  wire logic                 req,       // sink request
  output logic                      outReady,
  output logic                      full,
  output logic                      val,
  output logic                      sop,
  output logic                      eop,
  output ldpcDecPkg::tagT           tag,
  output logic [pDatW-1:0]          dat,
  output logic                      decFail,
  output ldpcDecPkg::errT           err
);
  import ldpcDecPkg::*;

  localparam int cBeatNum = cBitNum / pDatW;
  localparam int cCntW    = (cBeatNum > 1) ? $clog2(cBeatNum) : 1;

  logic [cCntW-1:0] beatCnt;
  logic             lastBeat;
  logic             sendBeat;
  logic             frameLoad;
  bitsT             bitsReg;
  decStatT          statReg;

  assign outReady  = !full;
  assign frameLoad = decVal && outReady;
  assign lastBeat  = (beatCnt == cCntW'(cBeatNum - 1));
  assign sendBeat  = full && req && !(val && eop);  // stop after eop

  //----------------------------------------
  // beat control
  //----------------------------------------
  always_ff @(posedge iclk or negedge rstN) begin
    if (!rstN) begin
      full    <= 1'b0;
      val     <= 1'b0;
      sop     <= 1'b0;
      eop     <= 1'b0;
      beatCnt <= '0;
    end else begin
      val <= sendBeat;
      if (sendBeat) begin
        sop     <= (beatCnt == '0);
        eop     <= lastBeat;
        beatCnt <= lastBeat ? '0 : beatCnt + 1'b1;
      end
      if (frameLoad) begin
        full <= 1'b1;
      end else if (val && eop) begin
        full <= 1'b0;  // freed once the eop beat is out
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (frameLoad) begin
      bitsReg <= decBits;
      statReg <= decStat;
    end
    if (sendBeat) begin
      dat <= bitsReg[beatCnt*pDatW +: pDatW];  // lowest bits first
    end
  end

  // status held for the whole frame
  assign tag     = statReg.tag;
  assign decFail = statReg.decFail;
  assign err     = statReg.err;

  aValFull: assert property (@(posedge iclk) disable iff (!rstN) val |-> full);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ldpcDecTb -f files.f \
  -o ldpcDecSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ldpcDecSim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
